//--- sim/aes_golden.txt
# op enc rs1 rs2 expected, all hex, one test per line
# op 0 sub, 1 subrot, 2 mix; enc 1 forward, 0 inverse
0 1 00000000 00000000 63636363
0 1 00530000 10000100 caed7c63
1 1 00530000 10000100 ed7c63ca
0 0 00ed0063 ca007c00 10530100
1 0 00ed0063 ca007c00 53010010
0 1 12ff340f c0aa9930 ba16ee76
0 0 aa16bb76 ba00ee55 c0ff990f
1 1 009a0030 e500c900 b8dd04d9
2 1 000013db 45530000 bca14d8e
2 0 00004d8e bca10000 455313db
2 1 00000af2 5c220000 9d58dc9f
2 1 0000d4d4 d5d40000 d6d7d5d5
2 0 a5a57e4d f8bd5a5a 4c31262d

//--- list.f
source/aes_pkg.sv
source/aes_sbox.sv
source/aes_sub.sv
source/aes_mix.sv
source/aes_unit.sv
sim/aes_unit_properties.sv
sim/tb_aes_unit.sv

//--- sim/tb_aes_unit.sv
// AES accelerator testbench
// Runs golden vectors from file, random round trips and a flush
// in the middle of a multi-cycle substitution, with a watchdog

`default_nettype none

module tb_aes_unit;

    localparam int    clock_period  = 40;
    localparam int    reset_cycles  = 4;
    localparam int    max_golden    = 32;             // Vectors the watchdog allows for
    localparam int    rand_runs     = 16;             // Each run issues four instructions
    localparam int    timeout_cycles = reset_cycles + 10 * (max_golden + 4 * rand_runs + 4);
    localparam string golden_path   = "sim/aes_golden.txt";

    logic                clock = 1'b0;
    logic                reset = 1'b1;
    logic                flush = 1'b0;
    logic                valid = 1'b0;
    aes_pkg::aes_op_t    op    = aes_pkg::op_sub;
    logic                enc   = 1'b1;
    aes_pkg::word_t      rs1   = '0;
    aes_pkg::word_t      rs2   = '0;
    logic                ready;
    aes_pkg::word_t      result;
    aes_pkg::word_t      rng_state = 32'h795d_8335;   // xorshift seed

    aes_unit #(
        .FAST (1'b0)
    ) UUT (
        .clock  (clock),
        .reset  (reset),
        .flush  (flush),
        .valid  (valid),
        .op     (op),
        .enc    (enc),
        .rs1    (rs1),
        .rs2    (rs2),
        .ready  (ready),
        .result (result)
    );

    always #(clock_period / 2) clock = ~clock;

    // Helpers
    // --------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input aes_pkg::word_t expected,
                              input aes_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
        end
    endtask

    function automatic aes_pkg::word_t xorshift32(input aes_pkg::word_t x);
        aes_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Hold valid until ready, then drop it and pulse flush
    task automatic issue(input string name, input aes_pkg::aes_op_t op_in, input logic enc_in,
                         input aes_pkg::word_t a, input aes_pkg::word_t b,
                         output aes_pkg::word_t res);
        @(posedge clock);
        valid <= 1'b1;
        op    <= op_in;
        enc   <= enc_in;
        rs1   <= a;
        rs2   <= b;
        @(negedge clock);
        while (!ready) begin
            @(negedge clock);                         // Sample mid-cycle
        end
        res = result;
        @(posedge clock);
        valid <= 1'b0;
        flush <= 1'b1;
        @(negedge clock);
        check_ready({name, " idle"}, 1'b0, ready);    // Gated off with valid low
        @(posedge clock);
        flush <= 1'b0;
    endtask

    // Tests
    // --------------------
    task automatic run_golden();
        int             fd;
        int             count;
        int             fields;
        string          line;
        logic [1:0]     f_op;
        logic           f_enc;
        aes_pkg::word_t f_rs1;
        aes_pkg::word_t f_rs2;
        aes_pkg::word_t f_exp;
        aes_pkg::word_t got;
        count = 0;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            abort_run("could not open the golden vector file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin   // Skip column notes
                fields = $sscanf(line, "%h %h %h %h %h", f_op, f_enc, f_rs1, f_rs2, f_exp);
                if (fields != 5) begin
                    abort_run("golden file holds a line without five fields");
                end
                count++;
                if (count > max_golden) begin
                    abort_run("golden file is longer than the watchdog allows");
                end
                issue($sformatf("golden_%0d", count), f_op, f_enc, f_rs1, f_rs2, got);
                check_word($sformatf("golden_%0d", count), f_exp, got);
            end
        end
        $fclose(fd);
        if (count == 0) begin
            abort_run("golden file held no test vectors");
        end
    endtask

    // Forward then inverse, fed back so each unit reselects its own bytes
    task automatic run_round_trips();
        aes_pkg::word_t a;
        aes_pkg::word_t b;
        aes_pkg::word_t mid;
        aes_pkg::word_t back;
        for (int i = 0; i < rand_runs; i++) begin
            rng_state = xorshift32(rng_state);
            a = rng_state;
            rng_state = xorshift32(rng_state);
            b = rng_state;
            issue($sformatf("sub_fwd_%0d", i), aes_pkg::op_sub, 1'b1, a, b, mid);
            issue($sformatf("sub_inv_%0d", i), aes_pkg::op_sub, 1'b0, mid, mid, back);
            check_word($sformatf("sub_round_trip_%0d", i),
                       {b[31:24], a[23:16], b[15:8], a[7:0]}, back);  // Bytes 3 2 1 0
            issue($sformatf("mix_fwd_%0d", i), aes_pkg::op_mix, 1'b1, a, b, mid);
            issue($sformatf("mix_inv_%0d", i), aes_pkg::op_mix, 1'b0, mid, mid, back);
            check_word($sformatf("mix_round_trip_%0d", i),
                       {b[31:24], b[23:16], a[15:8], a[7:0]}, back);  // Column a3..a0
        end
    endtask

    // Abandon a substitution half way, then run a clean one
    task automatic run_flush_test();
        aes_pkg::word_t got;
        @(posedge clock);
        valid <= 1'b1;
        op    <= aes_pkg::op_sub;
        enc   <= 1'b1;
        rs1   <= 32'h5353_5353;                       // Leaves ED in stored bytes
        rs2   <= 32'h5353_5353;
        repeat (2) begin
            @(negedge clock);
            check_ready("flush_partial", 1'b0, ready);
        end
        @(posedge clock);
        valid <= 1'b0;
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        @(negedge clock);
        check_ready("flush_idle", 1'b0, ready);
        issue("flush_next", aes_pkg::op_sub, 1'b1, 32'h0000_0000, 32'h0000_0000, got);
        check_word("flush_next", 32'h6363_6363, got);
    endtask

    // Sequence
    // --------------------
    initial begin
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_ready("reset_idle", 1'b0, ready);       // Valid still low
        run_golden();
        run_flush_test();
        run_round_trips();
        @(negedge clock);
        if (UUT.u_props.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("a bound assertion on the DUT strobes failed");
        end
    end

    // Bound assertion monitor
    initial begin
        wait (UUT.u_props.fail_count != 0);
        abort_run("a bound assertion on the DUT strobes failed");
    end

    // Watchdog
    initial begin
        #(clock_period * timeout_cycles);
        abort_run("run timed out before all tests finished");
    end

endmodule

`default_nettype wire

//--- sim/aes_unit_properties.sv
// AES accelerator strobe properties
// Bound to the top level, watches ready, flush and the lookup FSM

`default_nettype none

module aes_unit_properties (
    input logic                clock,
    input logic                reset,
    input logic                flush,
    input logic                valid,
    input aes_pkg::aes_op_t    op,
    input logic                ready,
    input aes_pkg::sub_state_t sub_state              // Multi-cycle lookup state
);

    int unsigned fail_count = 0;                      // Failed assertions so far

    // Ready is gated by valid in every build
    ready_needs_valid: assert property (@(posedge clock) disable iff (reset)
        ready |-> valid)
        else begin
            $error("ready high while valid is low");
            fail_count++;
        end

    // Flush returns the FSM to its first lookup
    flush_clears_state: assert property (@(posedge clock) disable iff (reset)
        flush |=> (sub_state == aes_pkg::lookup_0))
        else begin
            $error("lookup state not cleared after flush");
            fail_count++;
        end

    // Column mixing has no latency
    mix_same_cycle: assert property (@(posedge clock) disable iff (reset)
        (op == aes_pkg::op_mix) |-> (ready == valid))
        else begin
            $error("mix ready differs from valid");
            fail_count++;
        end

endmodule

bind aes_unit aes_unit_properties u_props (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .valid     (valid),
    .op        (op),
    .ready     (ready),
    .sub_state (u_sub.g_multi.state)
);

`default_nettype wire

//--- source/aes_unit.sv
// AES instruction accelerator top level
// Decodes the issued op, raises valid on the addressed unit and
// returns that unit's ready and result

`default_nettype none

module aes_unit #(
    parameter bit FAST = 1'b0                       // Substitution build select
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            flush,                  // One-cycle clear pulse
    input  logic            valid,                  // Held until ready
    input  aes_pkg::aes_op_t op,
    input  logic            enc,                    // Encrypt direction when set
    input  aes_pkg::word_t  rs1,
    input  aes_pkg::word_t  rs2,
    output logic            ready,
    output aes_pkg::word_t  result
);

    // Op decode
    // --------------------
    logic           is_sub;                         // op_sub or op_subrot
    logic           is_mix;
    logic           sub_valid;
    logic           sub_rot;
    logic           sub_ready;
    logic           mix_valid;
    logic           mix_ready;
    aes_pkg::word_t sub_result;
    aes_pkg::word_t mix_result;

    assign is_sub    = (op == aes_pkg::op_sub) || (op == aes_pkg::op_subrot);
    assign is_mix    = (op == aes_pkg::op_mix);
    assign sub_valid = valid && is_sub;
    assign sub_rot   = (op == aes_pkg::op_subrot); // RotWord form
    assign mix_valid = valid && is_mix;

    aes_sub #(
        .FAST (FAST)
    ) u_sub (
        .clock  (clock),
        .reset  (reset),
        .flush  (flush),
        .valid  (sub_valid),
        .rs1    (rs1),
        .rs2    (rs2),
        .enc    (enc),
        .rot    (sub_rot),
        .ready  (sub_ready),
        .result (sub_result)
    );

    aes_mix u_mix (
        .valid  (mix_valid),
        .rs1    (rs1),
        .rs2    (rs2),
        .enc    (enc),
        .ready  (mix_ready),
        .result (mix_result)
    );

    // Return path from the addressed unit
    assign ready  = is_mix ? mix_ready : sub_ready;
    assign result = is_mix ? mix_result : sub_result;

endmodule

`default_nettype wire

//--- source/aes_mix.sv
// AES MixColumns instruction unit
// Mixes one column taken from rs1 and rs2, forward or inverse,
// completing in the cycle valid is high

`default_nettype none

module aes_mix (
    input  logic           valid,                   // Instruction present
    input  aes_pkg::word_t rs1,                     // Column bytes 0 and 1
    input  aes_pkg::word_t rs2,                     // Column bytes 2 and 3
    input  logic           enc,                     // Forward mix when set
    output logic           ready,
    output aes_pkg::word_t result
);

    // Column and its multiples
    // --------------------
    aes_pkg::byte_t col   [4];
    aes_pkg::byte_t m2    [4];
    aes_pkg::byte_t m3    [4];
    aes_pkg::byte_t m4    [4];
    aes_pkg::byte_t m8    [4];
    aes_pkg::byte_t m9    [4];
    aes_pkg::byte_t m11   [4];
    aes_pkg::byte_t m13   [4];
    aes_pkg::byte_t m14   [4];
    aes_pkg::byte_t mixed [4];                      // Output column

    assign col[0] = rs1[7:0];
    assign col[1] = rs1[15:8];
    assign col[2] = rs2[23:16];
    assign col[3] = rs2[31:24];

    for (genvar i = 0; i < 4; i++) begin : g_mult
        assign m2[i]  = aes_pkg::xtime(col[i]);     // Doubling chain
        assign m4[i]  = aes_pkg::xtime(m2[i]);
        assign m8[i]  = aes_pkg::xtime(m4[i]);
        assign m3[i]  = m2[i] ^ col[i];
        assign m9[i]  = m8[i] ^ col[i];
        assign m11[i] = m8[i] ^ m2[i] ^ col[i];
        assign m13[i] = m8[i] ^ m4[i] ^ col[i];
        assign m14[i] = m8[i] ^ m4[i] ^ m2[i];
    end

    // Row of the mix matrix, rotated per output byte
    // --------------------
    for (genvar i = 0; i < 4; i++) begin : g_row
        assign mixed[i] = enc
            ? (m2[i] ^ m3[(i + 1) % 4] ^ col[(i + 2) % 4] ^ col[(i + 3) % 4])  // 2 3 1 1
            : (m14[i] ^ m11[(i + 1) % 4] ^ m13[(i + 2) % 4] ^ m9[(i + 3) % 4]); // 14 11 13 9
    end

    assign ready  = valid;                          // Purely combinational
    assign result = {mixed[3], mixed[2], mixed[1], mixed[0]};

endmodule

`default_nettype wire

//--- source/aes_sub.sv
// AES SubBytes instruction unit
// Four S-box lookups on bytes picked from rs1 and rs2, optional RotWord.
// FAST=1 uses four S-boxes and completes in the valid cycle,
// FAST=0 shares one S-box over four cycles

`default_nettype none

module aes_sub #(
    parameter bit FAST = 1'b0                       // Single-cycle build when set
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           flush,                   // Clears partial work
    input  logic           valid,                   // Held until ready
    input  aes_pkg::word_t rs1,
    input  aes_pkg::word_t rs2,
    input  logic           enc,                     // Forward S-box when set
    input  logic           rot,                     // Pack as SubWord plus RotWord
    output logic           ready,                   // Result valid this cycle
    output aes_pkg::word_t result
);

    // Source byte selection, shared by both builds
    aes_pkg::byte_t src [4];

    assign src[0] = rs1[7:0];
    assign src[1] = rs2[15:8];
    assign src[2] = rs1[23:16];
    assign src[3] = rs2[31:24];

    if (FAST) begin : g_fast

        // Single-cycle build
        // --------------------
        aes_pkg::byte_t sb_in  [4];
        aes_pkg::byte_t sb_out [4];

        for (genvar i = 0; i < 4; i++) begin : g_lane
            assign sb_in[i] = src[i] & {8{valid}};  // Quiet S-box when idle

            aes_sbox u_sbox (
                .in  (sb_in[i]),
                .inv (!enc),
                .out (sb_out[i])
            );
        end

        assign ready  = valid;
        assign result = rot ? {sb_out[2], sb_out[1], sb_out[0], sb_out[3]}
                            : {sb_out[3], sb_out[2], sb_out[1], sb_out[0]};

    end else begin : g_multi

        // Multi-cycle build
        // --------------------
        aes_pkg::sub_state_t state;                 // Current lookup
        aes_pkg::sub_state_t state_next;
        aes_pkg::byte_t      sel_byte;              // Byte for this lookup
        aes_pkg::byte_t      sbox_in;
        aes_pkg::byte_t      sbox_out;
        aes_pkg::byte_t      b_0;                   // Stored lookup results
        aes_pkg::byte_t      b_1;
        aes_pkg::byte_t      b_2;

        always_comb begin
            case (state)
                aes_pkg::lookup_0: sel_byte = src[0];
                aes_pkg::lookup_1: sel_byte = src[1];
                aes_pkg::lookup_2: sel_byte = src[2];
                default:           sel_byte = src[3];
            endcase
        end

        assign sbox_in = sel_byte & {8{valid}};     // Masked when idle

        aes_sbox u_sbox (
            .in  (sbox_in),
            .inv (!enc),
            .out (sbox_out)
        );

        assign ready = valid && (state == aes_pkg::lookup_3); // Fourth valid cycle

        always_comb begin
            case (state)
                aes_pkg::lookup_0: state_next = aes_pkg::lookup_1;
                aes_pkg::lookup_1: state_next = aes_pkg::lookup_2;
                default:           state_next = aes_pkg::lookup_3; // Hold at last
            endcase
        end

        always_ff @(posedge clock) begin
            if (reset || flush) begin
                state <= aes_pkg::lookup_0;
            end else if (valid && !ready) begin
                state <= state_next;                // Step once per held cycle
            end
        end

        always_ff @(posedge clock) begin
            if (reset || flush) begin
                b_0 <= '0;
                b_1 <= '0;
                b_2 <= '0;
            end else if (valid) begin
                case (state)
                    aes_pkg::lookup_0: b_0 <= sbox_out;
                    aes_pkg::lookup_1: b_1 <= sbox_out;
                    aes_pkg::lookup_2: b_2 <= sbox_out;
                    default:           ;        // Byte 3 taken live
                endcase
            end
        end

        assign result = rot ? {b_2, b_1, b_0, sbox_out}
                            : {sbox_out, b_2, b_1, b_0};

    end

endmodule

`default_nettype wire

//--- source/aes_sbox.sv
// AES S-box, forward and inverse
// Field inverse as x^254 through a square and multiply chain,
// wrapped by the affine map or its inverse. No lookup table

`default_nettype none

module aes_sbox (
    input  aes_pkg::byte_t in,                      // Byte to substitute
    input  logic           inv,                     // Inverse lookup when set
    output aes_pkg::byte_t out                      // Substituted byte
);

    // Field helpers
    // --------------------

    // Shift and add multiply, reduced each step
    function automatic aes_pkg::byte_t gf_mul(
        input aes_pkg::byte_t a,
        input aes_pkg::byte_t b
    );
        aes_pkg::byte_t acc;
        aes_pkg::byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;                     // Add this power of a
            end
            sh = aes_pkg::xtime(sh);                // Next a * x^i
        end
        return acc;
    endfunction

    // Rotate left by k bits
    function automatic aes_pkg::byte_t rotl(
        input aes_pkg::byte_t b,
        input int unsigned    k
    );
        return aes_pkg::byte_t'((b << k) | (b >> (8 - k)));
    endfunction

    // b_i ^ b_(i+4) ^ b_(i+5) ^ b_(i+6) ^ b_(i+7) ^ c_i
    function automatic aes_pkg::byte_t fwd_affine(input aes_pkg::byte_t b);
        return b ^ rotl(b, 1) ^ rotl(b, 2) ^ rotl(b, 3) ^ rotl(b, 4)
                 ^ aes_pkg::affine_fwd;
    endfunction

    // b_(i+2) ^ b_(i+5) ^ b_(i+7) ^ d_i
    function automatic aes_pkg::byte_t inv_affine(input aes_pkg::byte_t b);
        return rotl(b, 1) ^ rotl(b, 3) ^ rotl(b, 6) ^ aes_pkg::affine_inv;
    endfunction

    // Datapath
    // --------------------
    aes_pkg::byte_t field_in;                       // Operand of the field inverse
    aes_pkg::byte_t x2;
    aes_pkg::byte_t x3;
    aes_pkg::byte_t x6;
    aes_pkg::byte_t x12;
    aes_pkg::byte_t x15;
    aes_pkg::byte_t x30;
    aes_pkg::byte_t x60;
    aes_pkg::byte_t x120;
    aes_pkg::byte_t x240;
    aes_pkg::byte_t x252;
    aes_pkg::byte_t x254;                           // Multiplicative inverse, 0 maps to 0

    assign field_in = inv ? inv_affine(in) : in;    // Inverse path undoes affine first

    // Addition chain for x^254
    assign x2   = gf_mul(field_in, field_in);
    assign x3   = gf_mul(x2, field_in);
    assign x6   = gf_mul(x3, x3);
    assign x12  = gf_mul(x6, x6);
    assign x15  = gf_mul(x12, x3);
    assign x30  = gf_mul(x15, x15);
    assign x60  = gf_mul(x30, x30);
    assign x120 = gf_mul(x60, x60);
    assign x240 = gf_mul(x120, x120);
    assign x252 = gf_mul(x240, x12);                // 240 + 12
    assign x254 = gf_mul(x252, x2);                 // 252 + 2

    assign out = inv ? x254 : fwd_affine(x254);     // Forward path applies affine last

endmodule

`default_nettype wire

//--- source/aes_pkg.sv
// AES accelerator shared definitions
// Word, byte and op types, substitution FSM states, field constants
// and the xtime doubling used by the S-box and column mixing

`default_nettype none

package aes_pkg;

    // Types
    // --------------------
    typedef logic [31:0] word_t;                    // Source or result register word
    typedef logic [7:0]  byte_t;                    // One AES state byte
    typedef logic [1:0]  aes_op_t;                  // Instruction selector

    localparam aes_op_t op_sub    = 2'd0;           // SubBytes
    localparam aes_op_t op_subrot = 2'd1;           // SubBytes plus RotWord
    localparam aes_op_t op_mix    = 2'd2;           // MixColumns, one column

    // Multi-cycle substitution, one lookup per state
    typedef enum logic [1:0] {
        lookup_0 = 2'd0,                            // Byte 0 lookup
        lookup_1 = 2'd1,                            // Byte 1 lookup
        lookup_2 = 2'd2,                            // Byte 2 lookup
        lookup_3 = 2'd3                             // Byte 3 lookup, ready
    } sub_state_t;

    // Field constants
    // --------------------
    localparam byte_t mix_poly   = 8'h1b;           // x^8 + x^4 + x^3 + x + 1, low byte
    localparam byte_t affine_fwd = 8'h63;           // Forward affine offset
    localparam byte_t affine_inv = 8'h05;           // Inverse affine offset

    // Multiply by x in GF(2^8)
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? mix_poly : 8'h00); // Reduce on carry out
    endfunction

endpackage

`default_nettype wire
